// ==== calc_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module calc_core (
  input  logic                  clk,
  input  logic                  rst,
  input  calc_pkg::key_event_t  key,
  input  logic                  not_empty,
  output logic                  pop,
  output calc_pkg::disp_value_t value
);

  calc_pkg::calc_state_t state;
  calc_pkg::key_op_t     op;
  calc_pkg::key_op_t     key_op;
  calc_pkg::mag_t        entry_mag;
  calc_pkg::mag_t        left_mag;
  calc_pkg::mag_t        res_mag;

  logic               entry_neg;
  logic               left_neg;
  logic               res_neg;
  logic               fresh;              // next digit starts a new entry
  logic [4:0]         dig;                // {valid, value}
  logic [13:0]        append;
  logic signed [11:0] lhs;
  logic signed [11:0] rhs;
  logic signed [11:0] sum;
  logic [11:0]        sum_abs;
  logic [19:0]        prod;
  logic [3:0]         conv_cnt;
  logic [11:0]        conv_bcd;
  logic [11:0]        bcd_next;

  function automatic logic [4:0] digit_of(input calc_pkg::byte_t code);
    logic [4:0] res;
    res = '0;
    for (int i = 0; i < 10; i++) begin
      if (code == calc_pkg::SCAN_MAIN_DIGITS[i] || code == calc_pkg::SCAN_PAD_DIGITS[i])
        res = {1'b1, 4'(i)};
    end
    return res;
  endfunction

  function automatic calc_pkg::bcd_t add3(input calc_pkg::bcd_t d);
    return (d >= 4'd5) ? d + 4'd3 : d;
  endfunction

  ////////////////////////////////////////
  // key decode and arithmetic

  assign pop    = (state == calc_pkg::CALC_IDLE) && not_empty; // head used in the same cycle
  assign dig    = digit_of(key.code);
  assign append = entry_mag * 4'd10 + dig[3:0];

  always_comb begin
    case (key.code)
      calc_pkg::SCAN_KEY_A: key_op = calc_pkg::OP_ADD;
      calc_pkg::SCAN_KEY_S: key_op = calc_pkg::OP_SUB;
      calc_pkg::SCAN_KEY_X: key_op = calc_pkg::OP_MUL;
      default:              key_op = calc_pkg::OP_NONE;
    endcase
  end

  // sign-magnitude operands turned signed for add and subtract
  always_comb begin
    lhs = {2'b00, left_mag};
    rhs = {2'b00, entry_mag};
    if (left_neg)  lhs = -lhs;
    if (entry_neg) rhs = -rhs;
    sum     = (op == calc_pkg::OP_SUB) ? lhs - rhs : lhs + rhs;
    sum_abs = sum[11] ? -sum : sum;
    prod    = left_mag * entry_mag;
    if (op == calc_pkg::OP_MUL) begin
      res_neg = (left_neg ^ entry_neg) && (prod != '0); // zero stays positive
      res_mag = (prod > calc_pkg::MAX_VALUE) ? calc_pkg::MAX_VALUE : prod[9:0];
    end else begin
      res_neg = sum[11];
      res_mag = (sum_abs > calc_pkg::MAX_VALUE) ? calc_pkg::MAX_VALUE : sum_abs[9:0];
    end
  end

  ////////////////////////////////////////
  // control FSM

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= calc_pkg::CALC_IDLE;
      op        <= calc_pkg::OP_NONE;
      entry_neg <= 1'b0;
      entry_mag <= '0;
      left_neg  <= 1'b0;
      left_mag  <= '0;
      fresh     <= 1'b0;
      conv_cnt  <= '0;
      value     <= '0;
    end else begin
      case (state)
        calc_pkg::CALC_IDLE: begin
          conv_cnt <= '0;
          if (pop && !key.ext) begin         // extended keys are ignored
            if (dig[4]) begin
              if (fresh) begin
                entry_neg <= 1'b0;
                entry_mag <= {6'd0, dig[3:0]};
                fresh     <= 1'b0;
              end else if (append <= calc_pkg::MAX_VALUE) begin
                entry_mag <= append[9:0];
              end
              state <= calc_pkg::CALC_CONVERT;
            end else if (key_op != calc_pkg::OP_NONE) begin
              left_neg <= entry_neg;
              left_mag <= entry_mag;
              op       <= key_op;
              fresh    <= 1'b1;
            end else if (key.code == calc_pkg::SCAN_KEY_C) begin
              op        <= calc_pkg::OP_NONE;
              entry_neg <= 1'b0;
              entry_mag <= '0;
              left_neg  <= 1'b0;
              left_mag  <= '0;
              fresh     <= 1'b0;
              value     <= '0;
            end else if (key.code == calc_pkg::SCAN_KEY_ENTER) begin
              if (op != calc_pkg::OP_NONE) begin
                entry_neg <= res_neg;
                entry_mag <= res_mag;
                op        <= calc_pkg::OP_NONE;
                fresh     <= 1'b1;
              end
              state <= calc_pkg::CALC_CONVERT;
            end
          end
        end
        calc_pkg::CALC_CONVERT: begin
          conv_cnt <= conv_cnt + 1'b1;
          if (conv_cnt == 4'd9) begin        // last of ten shifts
            state <= calc_pkg::CALC_IDLE;
            value <= {entry_neg, bcd_next};
          end
        end
        default: state <= calc_pkg::CALC_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // shift-and-add-three, msb of entry_mag first

  assign bcd_next = {add3(conv_bcd[11:8]), add3(conv_bcd[7:4]), add3(conv_bcd[3:0])} << 1
                  | {11'd0, entry_mag[4'd9 - conv_cnt]};

  always_ff @(posedge clk) begin
    if (state == calc_pkg::CALC_IDLE) conv_bcd <= '0;
    else                              conv_bcd <= bcd_next;
  end

  a_convert_len: assert property (@(posedge clk) disable iff (rst)
    $rose(state == calc_pkg::CALC_CONVERT) |-> ##[1:10] (state == calc_pkg::CALC_IDLE));

endmodule

`default_nettype wire

// ==== calc_pkg.sv ====
`default_nettype none

package calc_pkg;

  ////////////////////////////////////////
  // basic widths

  typedef logic [7:0] byte_t;              // scan code or data byte
  typedef logic [9:0] mag_t;               // unsigned magnitude 0..999
  typedef logic [3:0] bcd_t;               // one decimal digit

  localparam mag_t MAX_VALUE = 10'd999;    // saturation limit

  ////////////////////////////////////////
  // structs

  typedef struct packed {
    logic  ext;                            // key came after an E0 prefix
    byte_t code;
  } key_event_t;

  typedef struct packed {
    logic neg;                             // show minus on the sign position
    bcd_t hundreds;
    bcd_t tens;
    bcd_t ones;
  } disp_value_t;

  ////////////////////////////////////////
  // enums

  typedef enum logic [1:0] {OP_NONE, OP_ADD, OP_SUB, OP_MUL} key_op_t;

  typedef enum logic [1:0] {RX_IDLE, RX_FALL, RX_LOW, RX_HIGH} rx_state_t;

  typedef enum logic [1:0] {DEC_MAKE, DEC_BREAK, DEC_EXTEND} dec_state_t;

  typedef enum logic {CALC_IDLE, CALC_CONVERT} calc_state_t;

  ////////////////////////////////////////
  // scan codes (set 2)

  localparam byte_t SCAN_BREAK     = 8'hF0;
  localparam byte_t SCAN_EXTEND    = 8'hE0;

  localparam byte_t SCAN_KEY_A     = 8'h1C; // add
  localparam byte_t SCAN_KEY_S     = 8'h1B; // subtract
  localparam byte_t SCAN_KEY_X     = 8'h22; // multiply
  localparam byte_t SCAN_KEY_C     = 8'h21; // clear
  localparam byte_t SCAN_KEY_ENTER = 8'h5A; // evaluate

  // index is the digit value
  localparam byte_t SCAN_MAIN_DIGITS [10] = '{
    8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46
  };
  localparam byte_t SCAN_PAD_DIGITS [10] = '{
    8'h70, 8'h69, 8'h72, 8'h7A, 8'h6B, 8'h73, 8'h74, 8'h6C, 8'h75, 8'h7D
  };

endpackage

`default_nettype wire

// ==== files.f ====
calc_pkg.sv
ps2_rx.sv
scan_decoder.sv
key_fifo.sv
calc_core.sv
seg_scan.sv
ps2_calc_top.sv
tb_ps2_calc.sv

// ==== key_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module key_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  calc_pkg::key_event_t wr_key,
  input  logic                 push,
  output calc_pkg::key_event_t rd_key,
  output logic                 not_empty,
  input  logic                 pop
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  calc_pkg::key_event_t mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_en;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) return '0;
    return ptr + 1'b1;
  endfunction

  assign wr_en     = push && (count != CNT_W'(FIFO_DEPTH)); // newest event lost when full
  assign not_empty = (count != '0);
  assign rd_key    = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= wr_key;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= ptr_inc(wr_ptr);
      if (pop)   rd_ptr <= ptr_inc(rd_ptr);
      case ({wr_en, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> not_empty);

endmodule

`default_nettype wire

// ==== ps2_calc_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module ps2_calc_top #(
  parameter int DEBOUNCE_CYCLES = 15,
  parameter int FIFO_DEPTH      = 4,
  parameter int SCAN_DIV_BITS   = 16
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output logic [6:0] seg,
  output logic [3:0] digit
);

  calc_pkg::byte_t       rx_byte;
  calc_pkg::key_event_t  dec_key;
  calc_pkg::key_event_t  head_key;
  calc_pkg::disp_value_t value;

  logic rx_valid;
  logic push;
  logic not_empty;
  logic pop;

  ////////////////////////////////////////
  // producer: receiver and decoder

  ps2_rx #(
    .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
  ) i_rx (
    .clk      (clk),
    .rst      (rst),
    .ps2_clk  (ps2_clk),
    .ps2_data (ps2_data),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid)
  );

  scan_decoder i_decoder (
    .clk      (clk),
    .rst      (rst),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid),
    .key      (dec_key),
    .push     (push)
  );

  ////////////////////////////////////////
  // buffer and consumer

  key_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) i_fifo (
    .clk       (clk),
    .rst       (rst),
    .wr_key    (dec_key),
    .push      (push),
    .rd_key    (head_key),
    .not_empty (not_empty),
    .pop       (pop)
  );

  calc_core i_core (
    .clk       (clk),
    .rst       (rst),
    .key       (head_key),
    .not_empty (not_empty),
    .pop       (pop),
    .value     (value)
  );

  seg_scan #(
    .SCAN_DIV_BITS(SCAN_DIV_BITS)
  ) i_seg (
    .clk   (clk),
    .rst   (rst),
    .value (value),
    .seg   (seg),
    .digit (digit)
  );

endmodule

`default_nettype wire

// ==== ps2_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module ps2_rx #(
  parameter int DEBOUNCE_CYCLES = 15
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            ps2_clk,
  input  logic            ps2_data,
  output calc_pkg::byte_t rx_byte,
  output logic            rx_valid
);

  localparam int CNT_W      = $clog2(DEBOUNCE_CYCLES + 1);
  localparam int FRAME_BITS = 11;

  calc_pkg::rx_state_t state;

  logic [1:0]  line_raw;
  logic [1:0]  line_stable;
  logic        clk_s;
  logic        data_s;
  logic [10:0] frame;
  logic [3:0]  bit_cnt;
  logic        frame_done;
  logic        parity_ok;

  ////////////////////////////////////////
  // line debouncers

  assign line_raw = {ps2_data, ps2_clk};

  for (genvar i = 0; i < 2; i++) begin : g_debounce
    logic             seen;
    logic             stable;
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
        seen   <= 1'b1;                      // idle bus is high
        stable <= 1'b1;
        cnt    <= '0;
      end else if (line_raw[i] != seen) begin
        seen <= line_raw[i];                 // restart the stable count
        cnt  <= '0;
      end else if (cnt == CNT_W'(DEBOUNCE_CYCLES)) begin
        stable <= seen;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end

    assign line_stable[i] = stable;
  end

  assign clk_s  = line_stable[0];
  assign data_s = line_stable[1];

  ////////////////////////////////////////
  // frame FSM

  assign frame_done = (state == calc_pkg::RX_LOW) && clk_s && (bit_cnt == 4'(FRAME_BITS));
  assign parity_ok  = ^frame[9:1];           // odd over data and parity

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= calc_pkg::RX_IDLE;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        calc_pkg::RX_IDLE: begin
          bit_cnt <= '0;
          if (!clk_s) state <= calc_pkg::RX_FALL;
        end
        calc_pkg::RX_FALL: begin
          bit_cnt <= bit_cnt + 1'b1;         // data sampled on this cycle
          state   <= calc_pkg::RX_LOW;
        end
        calc_pkg::RX_LOW: begin
          if (frame_done) begin
            state    <= calc_pkg::RX_IDLE;
            rx_valid <= parity_ok;           // bad frames are dropped silently
          end else if (clk_s) begin
            state <= calc_pkg::RX_HIGH;
          end
        end
        calc_pkg::RX_HIGH: begin
          if (!clk_s) state <= calc_pkg::RX_FALL;
        end
        default: state <= calc_pkg::RX_IDLE;
      endcase
    end
  end

  // lsb first, start bit ends up in frame[0]
  always_ff @(posedge clk) begin
    if (state == calc_pkg::RX_FALL) frame <= {data_s, frame[10:1]};
  end

  always_ff @(posedge clk) begin
    if (frame_done) rx_byte <= frame[8:1];
  end

  a_bit_cnt_range: assert property (@(posedge clk) disable iff (rst)
    bit_cnt <= 4'(FRAME_BITS));

endmodule

`default_nettype wire

// ==== scan_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module scan_decoder (
  input  logic                 clk,
  input  logic                 rst,
  input  calc_pkg::byte_t      rx_byte,
  input  logic                 rx_valid,
  output calc_pkg::key_event_t key,
  output logic                 push
);

  calc_pkg::dec_state_t state;

  logic is_prefix;

  assign is_prefix = (rx_byte == calc_pkg::SCAN_BREAK) || (rx_byte == calc_pkg::SCAN_EXTEND);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= calc_pkg::DEC_MAKE;
      push  <= 1'b0;
    end else begin
      // presses only, the byte after F0 is swallowed
      push <= rx_valid && !is_prefix && (state != calc_pkg::DEC_BREAK);
      if (rx_valid) begin
        if (rx_byte == calc_pkg::SCAN_BREAK) begin
          state <= calc_pkg::DEC_BREAK;      // also covers E0 F0
        end else if (state == calc_pkg::DEC_BREAK) begin
          state <= calc_pkg::DEC_MAKE;
        end else if (rx_byte == calc_pkg::SCAN_EXTEND) begin
          state <= calc_pkg::DEC_EXTEND;
        end else begin
          state <= calc_pkg::DEC_MAKE;
        end
      end
    end
  end

  // event payload, only meaningful together with push
  always_ff @(posedge clk) begin
    if (rx_valid) begin
      key.ext  <= (state == calc_pkg::DEC_EXTEND);
      key.code <= rx_byte;
    end
  end

endmodule

`default_nettype wire

// ==== seg_scan.sv ====
`timescale 1ns/100ps
`default_nettype none

module seg_scan #(
  parameter int SCAN_DIV_BITS = 16
) (
  input  logic                  clk,
  input  logic                  rst,
  input  calc_pkg::disp_value_t value,
  output logic [6:0]            seg,
  output logic [3:0]            digit
);

  localparam logic [3:0] CODE_BLANK = 4'hE;
  localparam logic [3:0] CODE_MINUS = 4'hF;

  logic [SCAN_DIV_BITS-1:0] div_cnt;
  logic [1:0]               pos;        // 0 ones, 1 tens, 2 hundreds, 3 sign
  logic [3:0]               code;
  logic [6:0]               pattern;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      div_cnt <= '0;
      pos     <= '0;
      seg     <= 7'b1111111;
      digit   <= 4'b1111;                 // all positions off in reset
    end else begin
      div_cnt <= div_cnt + 1'b1;
      if (div_cnt == '1) pos <= pos + 1'b1;
      seg     <= pattern;
      digit   <= ~(4'b0001 << pos);
    end
  end

  // leading zero blanking
  always_comb begin
    case (pos)
      2'd0:    code = value.ones;
      2'd1:    code = (value.hundreds == '0 && value.tens == '0) ? CODE_BLANK : value.tens;
      2'd2:    code = (value.hundreds == '0) ? CODE_BLANK : value.hundreds;
      default: code = value.neg ? CODE_MINUS : CODE_BLANK;
    endcase
  end

  always_comb begin
    case (code)
      4'd0:       pattern = 7'b1000000;
      4'd1:       pattern = 7'b1111001;
      4'd2:       pattern = 7'b0100100;
      4'd3:       pattern = 7'b0110000;
      4'd4:       pattern = 7'b0011001;
      4'd5:       pattern = 7'b0010010;
      4'd6:       pattern = 7'b0000010;
      4'd7:       pattern = 7'b1111000;
      4'd8:       pattern = 7'b0000000;
      4'd9:       pattern = 7'b0010000;
      CODE_MINUS: pattern = 7'b0111111; // middle bar only
      default:    pattern = 7'b1111111;
    endcase
  end

  a_one_digit: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) |-> $onehot(~digit));

endmodule

`default_nettype wire

// ==== tb_ps2_calc.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_ps2_calc;

  localparam int         HALF_BIT   = 40;          // ps2 clock half period in clk cycles
  localparam int         SETTLE_RUN = 40;          // more than one full scan round
  localparam int         WAIT_LIMIT = 4000;
  localparam logic [6:0] SEG_BLANK  = 7'b1111111;
  localparam logic [6:0] SEG_MINUS  = 7'b0111111;

  logic              clk;
  logic              rst;
  logic              ps2_clk;
  logic              ps2_data;
  logic [6:0]        seg;
  logic [3:0]        digit;
  logic              exp_neg;                       // model entry as the display shows it
  int                exp_mag;
  logic              left_neg;
  int                left_mag;
  calc_pkg::key_op_t pend_op;
  logic              fresh;
  logic              settled;                       // display must match the model
  logic [6:0]        exp_seg;
  int                seed;

  ps2_calc_top #(
    .DEBOUNCE_CYCLES (3),
    .FIFO_DEPTH      (4),
    .SCAN_DIV_BITS   (3)
  ) i_dut (
    .clk      (clk),
    .rst      (rst),
    .ps2_clk  (ps2_clk),
    .ps2_data (ps2_data),
    .seg      (seg),
    .digit    (digit)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  ////////////////////////////////////////
  // display model

  function automatic logic [6:0] digit_pattern(input int d);
    case (d)
      0:       return 7'b1000000;
      1:       return 7'b1111001;
      2:       return 7'b0100100;
      3:       return 7'b0110000;
      4:       return 7'b0011001;
      5:       return 7'b0010010;
      6:       return 7'b0000010;
      7:       return 7'b1111000;
      8:       return 7'b0000000;
      9:       return 7'b0010000;
      default: return SEG_BLANK;
    endcase
  endfunction

  function automatic logic [6:0] expected_pattern(input logic [3:0] dig, input logic neg,
                                                  input int mag);
    int h;
    int t;
    h = mag / 100;
    t = (mag / 10) % 10;
    case (dig)
      4'b1110: return digit_pattern(mag % 10);
      4'b1101: return (h == 0 && t == 0) ? SEG_BLANK : digit_pattern(t);
      4'b1011: return (h == 0) ? SEG_BLANK : digit_pattern(h);
      4'b0111: return neg ? SEG_MINUS : SEG_BLANK;
      default: return SEG_BLANK;
    endcase
  endfunction

  always_comb exp_seg = expected_pattern(digit, exp_neg, exp_mag);

  a_reset_blank: assert property (@(posedge clk) rst |-> (digit == 4'b1111))
    else report_failure($sformatf("MISMATCH at time %0t: digit expected 1111 got %b",
                                  $time, $sampled(digit)));

  a_seg_value: assert property (@(posedge clk) disable iff (rst || !settled)
    (digit != 4'b1111) |-> (seg == exp_seg))
    else report_failure($sformatf("MISMATCH at time %0t: seg expected %b got %b (digit %b)",
                                  $time, $sampled(exp_seg), $sampled(seg), $sampled(digit)));

  ////////////////////////////////////////
  // calculator model

  task automatic set_expect(input logic neg, input int mag);
    if (neg != exp_neg || mag != exp_mag) settled = 1'b0; // display is about to move
    exp_neg = neg;
    exp_mag = mag;
  endtask

  task automatic model_digit(input int d);
    if (fresh) begin
      fresh = 1'b0;
      set_expect(1'b0, d);
    end else if (exp_mag * 10 + d <= 999) begin
      set_expect(exp_neg, exp_mag * 10 + d);
    end
  endtask

  task automatic model_enter();
    int l;
    int r;
    int res;
    if (pend_op != calc_pkg::OP_NONE) begin
      l = left_neg ? -left_mag : left_mag;
      r = exp_neg ? -exp_mag : exp_mag;
      case (pend_op)
        calc_pkg::OP_ADD: res = l + r;
        calc_pkg::OP_SUB: res = l - r;
        default:          res = l * r;
      endcase
      if (res > 999) res = 999;
      else if (res < -999) res = -999;
      set_expect(res < 0, (res < 0) ? -res : res);
      pend_op = calc_pkg::OP_NONE;
      fresh   = 1'b1;
    end
  endtask

  ////////////////////////////////////////
  // ps2 stimulus

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic send_byte(input calc_pkg::byte_t code, input bit bad_parity);
    logic [10:0] frame;
    frame = {1'b1, (~^code) ^ bad_parity, code, 1'b0}; // stop, odd parity, data, start
    for (int i = 0; i < 11; i++) begin
      ps2_data = frame[i];
      idle_cycles(HALF_BIT / 2);
      ps2_clk = 1'b0;
      idle_cycles(HALF_BIT);
      ps2_clk = 1'b1;
      idle_cycles(HALF_BIT / 2);
    end
    ps2_data = 1'b1;
    idle_cycles(60);                                // frame fully through the chain
  endtask

  task automatic send_make(input calc_pkg::byte_t code, input bit ext);
    if (ext) send_byte(calc_pkg::SCAN_EXTEND, 1'b0);
    send_byte(code, 1'b0);
  endtask

  task automatic send_release(input calc_pkg::byte_t code, input bit ext);
    if (ext) send_byte(calc_pkg::SCAN_EXTEND, 1'b0);
    send_byte(calc_pkg::SCAN_BREAK, 1'b0);
    send_byte(code, 1'b0);
  endtask

  task automatic wait_display();
    int run;
    int n;
    run = 0;
    n   = 0;
    while (run < SETTLE_RUN && n < WAIT_LIMIT) begin
      idle_cycles(1);
      n++;
      if (digit != 4'b1111 && seg == expected_pattern(digit, exp_neg, exp_mag)) run++;
      else run = 0;
    end
    if (run < SETTLE_RUN)
      report_failure($sformatf("display never showed the expected value %0s%0d",
                               exp_neg ? "-" : "", exp_mag));
    else
      settled = 1'b1;
  endtask

  task automatic strike(input calc_pkg::byte_t code, input bit ext);
    send_make(code, ext);
    wait_display();
    send_release(code, ext);                        // checked while settled
  endtask

  task automatic type_digit(input int d, input bit pad);
    model_digit(d);
    strike(pad ? calc_pkg::SCAN_PAD_DIGITS[d] : calc_pkg::SCAN_MAIN_DIGITS[d], 1'b0);
  endtask

  task automatic type_number(input int n, input bit pad);
    if (n >= 100) type_digit(n / 100, pad);
    if (n >= 10) type_digit((n / 10) % 10, !pad);
    type_digit(n % 10, pad);
  endtask

  task automatic type_op(input calc_pkg::key_op_t op);
    left_neg = exp_neg;
    left_mag = exp_mag;
    pend_op  = op;
    fresh    = 1'b1;
    case (op)
      calc_pkg::OP_ADD: strike(calc_pkg::SCAN_KEY_A, 1'b0);
      calc_pkg::OP_SUB: strike(calc_pkg::SCAN_KEY_S, 1'b0);
      default:          strike(calc_pkg::SCAN_KEY_X, 1'b0);
    endcase
  endtask

  task automatic type_enter();
    model_enter();
    strike(calc_pkg::SCAN_KEY_ENTER, 1'b0);
  endtask

  task automatic type_clear();
    pend_op  = calc_pkg::OP_NONE;
    left_neg = 1'b0;
    left_mag = 0;
    fresh    = 1'b0;
    set_expect(1'b0, 0);
    strike(calc_pkg::SCAN_KEY_C, 1'b0);
  endtask

  ////////////////////////////////////////
  // test sequence

  initial begin
    int unsigned r;
    seed     = 84;
    rst      = 1'b0;
    ps2_clk  = 1'b1;
    ps2_data = 1'b1;
    settled  = 1'b0;
    exp_neg  = 1'b0;
    exp_mag  = 0;
    left_neg = 1'b0;
    left_mag = 0;
    pend_op  = calc_pkg::OP_NONE;
    fresh    = 1'b0;
    #1 rst = 1'b1;
    idle_cycles(2);
    rst = 1'b0;
    wait_display();                                 // 0 after reset

    type_digit(4, 1'b0);                            // leading blanking as it grows
    type_digit(0, 1'b1);
    type_digit(7, 1'b0);
    type_digit(5, 1'b1);                            // 4075 is over the limit

    type_clear();
    type_number(12, 1'b0);
    type_op(calc_pkg::OP_SUB);
    type_number(345, 1'b1);
    type_enter();                                   // negative result
    for (int i = 0; i < 6; i++) begin
      r = $unsigned($random(seed));
      if (r[0]) begin
        type_op(calc_pkg::OP_ADD);
        type_number((r >> 1) % 1000, i[0]);
      end else begin
        type_op(calc_pkg::OP_MUL);
        type_number((r >> 1) % 12, i[0]);
      end
      type_enter();
    end

    type_clear();                                   // saturation both ways
    type_number(500, 1'b0);
    type_op(calc_pkg::OP_MUL);
    type_number(3, 1'b1);
    type_enter();
    type_op(calc_pkg::OP_ADD);
    type_number(1, 1'b0);
    type_enter();
    type_clear();
    type_number(50, 1'b0);
    type_op(calc_pkg::OP_SUB);
    type_number(999, 1'b1);
    type_enter();
    type_op(calc_pkg::OP_MUL);
    type_number(2, 1'b0);
    type_enter();
    type_op(calc_pkg::OP_SUB);
    type_number(5, 1'b1);
    type_enter();

    type_clear();                                   // clear drops the minus sign
    type_number(25, 1'b0);
    type_op(calc_pkg::OP_ADD);
    type_number(3, 1'b1);
    type_clear();
    type_enter();
    type_number(7, 1'b0);
    type_op(calc_pkg::OP_MUL);
    type_clear();

    type_number(6, 1'b0);
    type_op(calc_pkg::OP_ADD);
    send_byte(calc_pkg::SCAN_MAIN_DIGITS[9], 1'b1); // bad parity gives no event
    strike(calc_pkg::SCAN_KEY_ENTER, 1'b1);         // keypad enter is ignored
    type_number(3, 1'b1);
    model_enter();                                  // enter and digit back to back
    model_digit(7);
    send_make(calc_pkg::SCAN_KEY_ENTER, 1'b0);
    send_make(calc_pkg::SCAN_MAIN_DIGITS[7], 1'b0);
    wait_display();
    send_release(calc_pkg::SCAN_KEY_ENTER, 1'b0);
    send_release(calc_pkg::SCAN_MAIN_DIGITS[7], 1'b0);
    idle_cycles(40);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire
